// File: sources.f
design/obj_pkg.sv
design/obj_apb_port.sv
design/obj_table_ram.sv
design/obj_scan.sv
design/obj_draw.sv
design/obj_line_buf.sv
design/obj_top.sv
testbench/obj_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the sprite engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module obj_tb -o obj_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/obj_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation run exited with status $status"
    exit 1
fi

# The log decides pass or fail
if grep -q "Simulation failed" "$LOG"; then
    exit 1
fi
exit 0

// File: testbench/obj_tb.sv
`timescale 1ns/1ps

module obj_tb;
    import obj_pkg::*;

    localparam int LINE_CYC = 1024;     // Cycles per video line
    localparam int APB_TMO  = 20;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    apb_req_t    apb_req;
    logic [15:0] prdata;
    logic        pready;
    logic        hstart;
    logic [8:0]  vrender;
    logic [8:0]  hdump;
    logic [18:0] rom_addr;
    logic        rom_cs;
    logic [31:0] rom_data;
    pix_t        pix_out;

    logic [31:0] rom [2**19];           // Sprite ROM contents
    logic [15:0] shadow [2**TBL_AW];    // Host copy of the object table
    pix_t        exp_next [512];        // Line being drawn
    pix_t        exp_cur [512];         // Line being shown
    pix_t        exp_d;
    logic [8:0]  hd_d;
    logic        sweep = 1'b0;
    logic        check_on = 1'b0;
    logic        chk_d = 1'b0;
    logic [15:0] rd_exp = '0;
    logic [31:0] rng = 32'h1656_2570;
    logic        tmo_hit = 1'b0;
    string       tmo_what;
    string       test_name = "reset";
    int          mism = 0;
    int          other = 0;
    logic [10:0] addrs [16];
    logic [18:0] fetch_q [$];           // Row address of each drawn object, in order
    logic        fetch_ph = 1'b0;       // Second word of the pair
    logic [18:0] fetch_exp;

    always #4 clk = ~clk;

    obj_top DUT (
        .clk(clk), .rst(rst), .apb_req(apb_req), .prdata(prdata), .pready(pready),
        .hstart(hstart), .vrender(vrender), .hdump(hdump),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data), .pix_out(pix_out)
    );

    // ROM with one cycle read latency
    always @(posedge clk)
        if (rom_cs)
            rom_data <= rom[rom_addr];

    // Each drawn object reads two ROM words at its row address
    always @(posedge clk) begin
        if (!rst && rom_cs) begin
            if (fetch_q.size() == 0) begin
                other++;
                $display("%s: ROM read with no object left to draw", test_name);
            end else begin
                fetch_exp = {fetch_q[0][18:1], fetch_ph};
                assert (rom_addr == fetch_exp)
                    else begin
                        mism++;
                        $display("Mismatch %s: ROM address expected %h actual %h",
                                 test_name, fetch_exp, rom_addr);
                    end
                if (fetch_ph)
                    void'(fetch_q.pop_front());
            end
            fetch_ph = ~fetch_ph;
        end
    end

    // Expected pixel lines up with the registered pix_out
    always @(posedge clk) begin
        chk_d <= sweep && check_on;
        exp_d <= exp_cur[hdump];
        hd_d  <= hdump;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // Taps 32 22 2 1
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rng = lfsr_step(rng);
            v   = {v[30:0], rng[0]};    // One step per bit
        end
        return v;
    endfunction

    // Reference for one scanned line, also advances shadow offsets
    task automatic draw_line(input int v);
        logic [7:0]  ln;
        logic [7:0]  top;
        logic [7:0]  bot;
        logic [15:0] off;
        logic [15:0] attr;
        logic [18:0] base;
        logic [63:0] row;
        logic [3:0]  nib;
        pix_t        p;
        int          col;
        int          idx;
        ln = v[7:0];
        for (int x = 0; x < 512; x++)
            exp_next[x] = '0;
        if (v >= VIS_LINES)
            return;
        for (int n = 0; n < 256; n++) begin
            top = shadow[n*8][7:0];
            bot = shadow[n*8][15:8];
            if (bot >= END_MARK)
                break;                  // Table ends here
            if (ln >= top && bot > ln && top < bot) begin
                off = shadow[n*8+3];
                if (ln != top)
                    off = off + shadow[n*8+2];
                shadow[n*8+3] = off;    // Written back by the scanner
                attr = shadow[n*8+4];
                base = {attr[6:4], off[14:0], 1'b0};
                fetch_q.push_back(base);
                row  = {rom[base], rom[base | 19'd1]};
                for (int i = 0; i < SPR_W; i++) begin
                    idx     = off[15] ? SPR_W - 1 - i : i;
                    nib     = row[63 - 4 * idx -: 4];
                    col     = int'(shadow[n*8+1][8:0]) + i;
                    p.prio  = attr[1:0];
                    p.pal   = attr[13:8];
                    p.color = nib;
                    if (nib != 4'd0 && col < LINE_W) begin
                        if (p.prio >= exp_next[col].prio || exp_next[col].color == 4'd0)
                            exp_next[col] = p;
                    end
                end
            end
        end
    endtask

    // One full line period: hstart, then a sweep of the visible columns
    task automatic run_line(input int v);
        @(posedge clk);
        hstart  <= 1'b1;
        vrender <= 9'(v);
        for (int x = 0; x < 512; x++)
            exp_cur[x] = exp_next[x];   // Drawn line goes on screen
        draw_line(v);
        @(posedge clk);
        hstart <= 1'b0;
        repeat (4) @(posedge clk);
        for (int x = 0; x < LINE_W; x++) begin
            @(posedge clk);
            hdump <= 9'(x);
            sweep <= 1'b1;
        end
        @(posedge clk);
        sweep <= 1'b0;
        hdump <= 9'd511;                // Beam parked outside the visible columns
        repeat (LINE_CYC - 327) @(posedge clk);
    endtask

    task automatic apb_xfer(input logic wr, input logic [10:0] addr, input logic [15:0] data);
        int n;
        @(posedge clk);
        apb_req <= '{sel: 1'b1, enable: 1'b0, write: wr, addr: addr, wdata: data};
        @(posedge clk);
        apb_req.enable <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!pready && n < APB_TMO) begin
            n++;
            @(negedge clk);
        end
        if (!pready) begin
            tmo_what = "APB transfer got no pready";
            tmo_hit  = 1'b1;
            wait (1'b0);                // Watchdog ends the run
        end
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic write_word(input logic [10:0] addr, input logic [15:0] data);
        shadow[addr] = data;
        apb_xfer(1'b1, addr, data);
    endtask

    task automatic read_word(input logic [10:0] addr);
        rd_exp = shadow[addr];          // Checked by the prdata assertion
        apb_xfer(1'b0, addr, 16'h0000);
    endtask

    task automatic set_entry(input int n, input logic [7:0] top, input logic [7:0] bot,
                             input logic [8:0] x, input logic [15:0] pitch,
                             input logic [15:0] off, input logic [5:0] pal,
                             input logic [2:0] bank, input logic [1:0] prio);
        write_word(11'(n * 8), {bot, top});
        write_word(11'(n * 8 + 1), {7'd0, x});
        write_word(11'(n * 8 + 2), pitch);
        write_word(11'(n * 8 + 3), off);
        write_word(11'(n * 8 + 4), {2'b00, pal, 1'b0, bank, 2'b00, prio});
    endtask

    task automatic finish_run();
        $display("Errors: %0d total, %0d mismatches, %0d other", mism + other, mism, other);
        if (mism + other == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    endtask

    always @(posedge tmo_hit) begin
        other++;
        $display("Timeout: %s", tmo_what);
        finish_run();
    end

    assert property (@(posedge clk) disable iff (rst) chk_d |-> pix_out == exp_d)
        else begin
            mism++;
            $display("Mismatch %s: column %0d expected %h actual %h",
                     test_name, $sampled(hd_d), $sampled(exp_d), $sampled(pix_out));
        end

    assert property (@(posedge clk) disable iff (rst)
        pready && !apb_req.write |-> prdata == rd_exp)
        else begin
            mism++;
            $display("Mismatch %s: read data expected %h actual %h",
                     test_name, $sampled(rd_exp), $sampled(prdata));
        end

    // One wait state on reads, none on writes
    assert property (@(posedge clk) disable iff (rst)
        apb_req.sel && $rose(apb_req.enable) && !apb_req.write |-> !pready)
        else begin
            other++;
            $display("%s: read completed without a wait state", test_name);
        end
    assert property (@(posedge clk) disable iff (rst)
        apb_req.sel && $rose(apb_req.enable) && !apb_req.write |=> pready)
        else begin
            other++;
            $display("%s: read not ready after one wait state", test_name);
        end
    assert property (@(posedge clk) disable iff (rst)
        apb_req.sel && $rose(apb_req.enable) && apb_req.write |-> pready)
        else begin
            other++;
            $display("%s: write not accepted in its first access cycle", test_name);
        end

    assert property (@(posedge clk) disable iff (rst) hstart |-> DUT.u_scan.st == S_IDLE)
        else begin
            other++;
            $display("%s: scanner still busy at line start", test_name);
        end

    initial begin
        apb_req  = '0;
        hstart   = 1'b0;
        vrender  = 9'd300;              // Below the visible area, no scan
        hdump    = '0;
        rom_data = '0;
        for (int a = 0; a < 2**TBL_AW; a++)
            shadow[a] = '0;
        for (int x = 0; x < 512; x++)
            exp_next[x] = '0;
        for (int a = 0; a < 2**19; a++)
            rom[a] = rand_bits(32);
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        test_name = "apb_rw";
        write_word(11'd0, 16'hF000);    // Empty table
        for (int i = 0; i < 16; i++) begin
            addrs[i] = 11'(1024 + rand_bits(10));
            write_word(addrs[i], 16'(rand_bits(16)));
        end
        for (int i = 0; i < 16; i++)
            read_word(addrs[i]);

        // Two sweeps clear both buffer halves
        run_line(300);
        run_line(300);
        check_on = 1'b1;

        test_name = "single";
        set_entry(0, 8'd10, 8'd14, 9'd100, 16'd1, 16'h0040, 6'd5, 3'd2, 2'd1);
        write_word(11'd8, 16'hF000);
        for (int v = 8; v <= 16; v++) begin
            run_line(v);
            read_word(11'd3);
        end

        test_name = "neg_pitch";
        set_entry(0, 8'd20, 8'd25, 9'd200, 16'hFFFD, 16'h0100, 6'd7, 3'd3, 2'd3);
        for (int v = 19; v <= 26; v++) begin
            run_line(v);
            read_word(11'd3);
        end

        test_name = "flip_bad_end";
        set_entry(0, 8'd30, 8'd33, 9'd310, 16'd2, 16'h8100, 6'd9, 3'd5, 2'd0);
        set_entry(1, 8'd32, 8'd31, 9'd40, 16'd1, 16'h0300, 6'd1, 3'd1, 2'd3);
        set_entry(2, 8'd30, 8'd33, 9'd60, 16'd1, 16'h0200, 6'd3, 3'd1, 2'd2);
        write_word(11'd24, 16'hF500);
        set_entry(4, 8'd30, 8'd33, 9'd80, 16'd1, 16'h0400, 6'd4, 3'd0, 2'd3);
        for (int v = 29; v <= 34; v++)
            run_line(v);

        test_name = "priority";
        set_entry(0, 8'd40, 8'd46, 9'd50, 16'd0, 16'h0010, 6'd1, 3'd0, 2'd2);
        set_entry(1, 8'd40, 8'd46, 9'd58, 16'd0, 16'h0020, 6'd2, 3'd1, 2'd1);
        set_entry(2, 8'd40, 8'd46, 9'd62, 16'd0, 16'h0030, 6'd3, 3'd2, 2'd1);
        write_word(11'd24, 16'hF000);
        for (int v = 39; v <= 42; v++)
            run_line(v);
        write_word(11'd8, 16'h0000);    // Entry 1 turns bad and drops out
        for (int v = 43; v <= 46; v++)
            run_line(v);

        test_name = "many";
        for (int n = 0; n < 24; n++)
            set_entry(n, 8'd60, 8'd62, 9'(rand_bits(8) + rand_bits(6)),
                      16'(rand_bits(4)), 16'(rand_bits(16)), 6'(rand_bits(6)),
                      3'(rand_bits(3)), 2'(rand_bits(2)));
        write_word(11'(24 * 8), 16'hF000);
        for (int v = 59; v <= 63; v++)
            run_line(v);

        // Objects still queued here were never fetched
        if (fetch_q.size() != 0) begin
            other++;
            $display("%0d drawn objects never read from the ROM", fetch_q.size());
        end

        finish_run();
    end

endmodule

// File: design/obj_top.sv
`timescale 1ns/1ps

module obj_top (
    input  logic              clk,
    input  logic              rst,
    input  obj_pkg::apb_req_t apb_req,
    output logic [15:0]       prdata,
    output logic              pready,
    input  logic              hstart,
    input  logic [8:0]        vrender,
    input  logic [8:0]        hdump,
    output logic [18:0]       rom_addr,
    output logic              rom_cs,
    input  logic [31:0]       rom_data,
    output obj_pkg::pix_t     pix_out
);
    import obj_pkg::*;

    tbl_acc_t    tbl_a;                 // Host side of the table
    tbl_acc_t    tbl_b;                 // Scanner side
    logic [15:0] a_dout;
    logic [15:0] b_dout;
    obj_cmd_t    cmd;
    logic        dr_start;
    logic        dr_busy;
    logic        wr_en;
    logic [8:0]  wr_x;
    pix_t        wr_pix;

    obj_apb_port u_apb (
        .clk(clk), .rst(rst), .apb_req(apb_req), .prdata(prdata), .pready(pready),
        .tbl_a(tbl_a), .tbl_a_dout(a_dout)
    );

    obj_table_ram u_ram (
        .clk(clk), .tbl_a(tbl_a), .a_dout(a_dout), .tbl_b(tbl_b), .b_dout(b_dout)
    );

    obj_scan u_scan (
        .clk(clk), .rst(rst), .hstart(hstart), .vrender(vrender),
        .tbl_b(tbl_b), .tbl_dout(b_dout),
        .cmd(cmd), .dr_start(dr_start), .dr_busy(dr_busy)
    );

    obj_draw u_draw (
        .clk(clk), .rst(rst), .cmd(cmd), .dr_start(dr_start), .dr_busy(dr_busy),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .rom_data(rom_data),
        .wr_en(wr_en), .wr_x(wr_x), .wr_pix(wr_pix)
    );

    obj_line_buf u_buf (
        .clk(clk), .rst(rst), .hstart(hstart),
        .wr_en(wr_en), .wr_x(wr_x), .wr_pix(wr_pix),
        .hdump(hdump), .pix_out(pix_out)
    );

endmodule

// File: design/obj_line_buf.sv
`timescale 1ns/1ps

module obj_line_buf (
    input  logic          clk,
    input  logic          rst,
    input  logic          hstart,
    input  logic          wr_en,
    input  logic [8:0]    wr_x,
    input  obj_pkg::pix_t wr_pix,
    input  logic [8:0]    hdump,
    output obj_pkg::pix_t pix_out
);
    import obj_pkg::*;

    // Both halves in one array, MSB picks the half
    pix_t mem [1024];
    logic front;                        // Half being shown
    pix_t old;
    logic take;

    // Pixel already drawn at the target column
    assign old  = mem[{~front, wr_x}];
    assign take = wr_pix.prio >= old.prio || old.color == 4'd0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            front <= 1'b0;
        else if (hstart)
            front <= ~front;            // Drawn line goes on screen
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            pix_out <= '0;
        else
            pix_out <= mem[{front, hdump}];
    end

    always_ff @(posedge clk) begin
        if (wr_en && take)
            mem[{~front, wr_x}] <= wr_pix;
        mem[{front, hdump}] <= '0;      // Clear behind the beam
    end

endmodule

// File: design/obj_draw.sv
`timescale 1ns/1ps

module obj_draw (
    input  logic              clk,
    input  logic              rst,
    input  obj_pkg::obj_cmd_t cmd,
    input  logic              dr_start,
    output logic              dr_busy,
    output logic [18:0]       rom_addr,
    output logic              rom_cs,
    input  logic [31:0]       rom_data,
    output logic              wr_en,
    output logic [8:0]        wr_x,
    output obj_pkg::pix_t     wr_pix
);
    import obj_pkg::*;

    draw_st_t st;
    obj_cmd_t cur;                      // Latched command
    logic [31:0] w0;                    // Left eight pixels
    logic [31:0] w1;                    // Right eight pixels
    logic [$clog2(SPR_W)-1:0] cnt;      // Pixel being written
    logic [63:0] row;
    logic [$clog2(SPR_W)-1:0] nib_idx;
    logic [3:0]  nib;
    logic [9:0]  col;                   // One spare bit for the edge check

    assign dr_busy  = st != D_IDLE;
    assign rom_cs   = st == D_FETCH0 || st == D_FETCH1;
    assign rom_addr = {cur.bank, cur.offset[14:0], st == D_FETCH1};

    // Second word arrives during the first write cycle
    assign row     = {w0, (cnt == 0) ? rom_data : w1};
    assign nib_idx = cur.offset[15] ? ($clog2(SPR_W))'(SPR_W - 1) - cnt : cnt;
    assign nib     = row[63 - 4 * int'(nib_idx) -: 4];
    assign col     = {1'b0, cur.xpos} + 10'(cnt);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st    <= D_IDLE;
            cnt   <= '0;
            wr_en <= 1'b0;
        end else begin
            wr_en <= 1'b0;
            case (st)
                D_IDLE: begin
                    if (dr_start) begin
                        cnt <= '0;
                        st  <= D_FETCH0;
                    end
                end
                D_FETCH0: st <= D_FETCH1;
                D_FETCH1: st <= D_WRITE;
                default: begin
                    // Skip transparent and off screen pixels
                    wr_en <= nib != 4'd0 && col < LINE_W;
                    cnt   <= cnt + 1'b1;
                    if (cnt == SPR_W - 1)
                        st <= D_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (st == D_IDLE && dr_start)
            cur <= cmd;
        if (st == D_FETCH1)
            w0 <= rom_data;
        if (st == D_WRITE && cnt == 0)
            w1 <= rom_data;
        if (st == D_WRITE) begin
            wr_x         <= col[8:0];
            wr_pix.prio  <= cur.prio;
            wr_pix.pal   <= cur.pal;
            wr_pix.color <= nib;
        end
    end

endmodule

// File: design/obj_scan.sv
`timescale 1ns/1ps

module obj_scan (
    input  logic              clk,
    input  logic              rst,
    input  logic              hstart,
    input  logic [8:0]        vrender,
    output obj_pkg::tbl_acc_t tbl_b,
    input  logic [15:0]       tbl_dout,
    output obj_pkg::obj_cmd_t cmd,
    output logic              dr_start,
    input  logic              dr_busy
);
    import obj_pkg::*;

    scan_st_t st;

    // Entry and word pointers
    logic [TBL_AW-$clog2(OBJ_WORDS)-1:0] cur_obj;
    logic [$clog2(OBJ_WORDS)-1:0]        idx;
    logic                                settle;  // Word 0 read still in flight
    logic                                first;   // Top line of the object

    // Fields gathered from the entry
    logic [8:0]         xpos;
    logic signed [15:0] pitch;
    logic [15:0]        offset;
    logic [2:0]         bank;
    logic [1:0]         prio;
    logic [5:0]         pal;

    logic [7:0] top;
    logic [7:0] bottom;
    logic       in_zone;
    logic       bad_obj;
    logic       last_obj;
    logic       end_mark;

    // Word 0 decode, valid in the CHECK decision cycle
    assign top      = tbl_dout[7:0];
    assign bottom   = tbl_dout[15:8];
    assign in_zone  = vrender[7:0] >= top && bottom > vrender[7:0];
    assign bad_obj  = top >= bottom;
    assign end_mark = bottom >= END_MARK;
    assign last_obj = &cur_obj;          // No entries past this one

    assign tbl_b.addr  = {cur_obj, idx};
    assign tbl_b.we    = st == S_WBACK;
    assign tbl_b.wdata = offset;         // Row address for the next line

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= S_IDLE;
            cur_obj  <= '0;
            idx      <= '0;
            settle   <= 1'b0;
            dr_start <= 1'b0;
        end else begin
            dr_start <= 1'b0;           // Single cycle pulse
            case (st)
                S_IDLE: begin
                    if (hstart && vrender < VIS_LINES) begin
                        cur_obj <= '0;
                        idx     <= '0;
                        settle  <= 1'b1;
                        st      <= S_CHECK;
                    end
                end
                S_CHECK: begin
                    if (settle) begin
                        settle <= 1'b0;
                        idx    <= 1;    // Prefetch xpos
                    end else if (end_mark) begin
                        st <= S_IDLE;   // Table done
                    end else if (!in_zone || bad_obj) begin
                        if (last_obj) begin
                            st <= S_IDLE;
                        end else begin
                            cur_obj <= cur_obj + 1'b1;
                            idx     <= '0;
                            settle  <= 1'b1;
                        end
                    end else begin
                        idx <= 2;
                        st  <= S_XPOS;
                    end
                end
                S_XPOS: begin
                    idx <= 3;
                    st  <= S_PITCH;
                end
                S_PITCH: begin
                    idx <= 4;
                    st  <= S_OFFSET;
                end
                S_OFFSET: begin
                    idx <= 3;           // Park on word 3 for write back
                    st  <= S_ATTR;
                end
                S_ATTR:  st <= S_WBACK;
                S_WBACK: st <= S_ISSUE;
                default: begin          // S_ISSUE, waits out the draw unit
                    if (!dr_busy) begin
                        dr_start <= 1'b1;
                        if (last_obj) begin
                            st <= S_IDLE;
                        end else begin
                            cur_obj <= cur_obj + 1'b1;
                            idx     <= '0;
                            settle  <= 1'b1;
                            st      <= S_CHECK;
                        end
                    end
                end
            endcase
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        case (st)
            S_CHECK: first <= top == vrender[7:0];
            S_XPOS:  xpos  <= tbl_dout[8:0];
            S_PITCH: pitch <= tbl_dout;
            S_OFFSET: begin
                if (first)
                    offset <= tbl_dout;             // Start row as stored
                else
                    offset <= tbl_dout + pitch;     // Advance one row
            end
            S_ATTR: begin
                pal  <= tbl_dout[13:8];
                bank <= tbl_dout[6:4];
                prio <= tbl_dout[1:0];
            end
            S_ISSUE: begin
                if (!dr_busy) begin
                    cmd.xpos   <= xpos;
                    cmd.offset <= offset;
                    cmd.bank   <= bank;
                    cmd.prio   <= prio;
                    cmd.pal    <= pal;
                end
            end
            default: ;
        endcase
    end

    // Handshake with the draw unit
    assert property (@(posedge clk) disable iff (rst) dr_start |-> !dr_busy)
        else $error("dr_start while draw unit busy");
    assert property (@(posedge clk) disable iff (rst) dr_start |=> !dr_start)
        else $error("dr_start longer than one cycle");

endmodule

// File: design/obj_table_ram.sv
`timescale 1ns/1ps

module obj_table_ram (
    input  logic              clk,
    input  obj_pkg::tbl_acc_t tbl_a,
    output logic [15:0]       a_dout,
    input  obj_pkg::tbl_acc_t tbl_b,
    output logic [15:0]       b_dout
);
    import obj_pkg::*;

    logic [15:0] mem [2**TBL_AW];

    always_ff @(posedge clk) begin
        if (tbl_a.we)
            mem[tbl_a.addr] <= tbl_a.wdata;    // Host side
        if (tbl_b.we)
            mem[tbl_b.addr] <= tbl_b.wdata;    // Scanner, last so it wins a clash
        a_dout <= mem[tbl_a.addr];
        b_dout <= mem[tbl_b.addr];
    end

endmodule

// File: design/obj_apb_port.sv
`timescale 1ns/1ps

module obj_apb_port (
    input  logic              clk,
    input  logic              rst,
    input  obj_pkg::apb_req_t apb_req,
    output logic [15:0]       prdata,
    output logic              pready,
    output obj_pkg::tbl_acc_t tbl_a,
    input  logic [15:0]       tbl_a_dout
);

    // Phase of the current APB cycle
    typedef enum logic [1:0] {
        A_IDLE,     // Idle or setup cycle
        A_ACCESS,   // First cycle with penable
        A_RWAIT     // Second access cycle of a read
    } apb_st_t;

    apb_st_t st;
    logic    access;

    assign access = apb_req.sel && apb_req.enable;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st <= A_IDLE;
        end else begin
            case (st)
                A_IDLE: begin
                    if (apb_req.sel && !apb_req.enable)
                        st <= A_ACCESS;         // Setup seen
                end
                A_ACCESS: begin
                    if (access && !apb_req.write)
                        st <= A_RWAIT;          // RAM data lands next cycle
                    else
                        st <= A_IDLE;
                end
                default: st <= A_IDLE;          // Read done
            endcase
        end
    end

    // Address follows the bus so the RAM sees it during setup too
    assign tbl_a.addr  = apb_req.addr;
    assign tbl_a.wdata = apb_req.wdata;
    assign tbl_a.we    = access && apb_req.write && st == A_ACCESS;

    // Writes finish at once, reads after one wait state
    assign pready = access && ((st == A_ACCESS && apb_req.write) || st == A_RWAIT);
    assign prdata = tbl_a_dout;

    // Access phase must follow a setup phase
    assert property (@(posedge clk) disable iff (rst)
        $rose(apb_req.enable) |-> apb_req.sel && $past(apb_req.sel))
        else $error("penable raised without psel");

endmodule

// File: design/obj_pkg.sv
package obj_pkg;

    // Object table geometry
    localparam int TBL_AW    = 11;      // Word address, 256 entries of 8 words
    localparam int OBJ_WORDS = 8;
    localparam int VIS_LINES = 224;     // No scan from here down
    localparam int SPR_W     = 16;      // Fixed sprite width
    localparam int LINE_W    = 320;     // Visible columns

    localparam logic [7:0] END_MARK = 8'hF0;   // Bottom byte that ends the table

    // Command from scanner to draw unit
    typedef struct packed {
        logic [8:0]  xpos;
        logic [15:0] offset;    // MSB doubles as h-flip
        logic [2:0]  bank;
        logic [1:0]  prio;
        logic [5:0]  pal;
    } obj_cmd_t;

    // APB master signals as seen at the top ports
    typedef struct packed {
        logic        sel;
        logic        enable;
        logic        write;
        logic [10:0] addr;
        logic [15:0] wdata;
    } apb_req_t;

    // One table RAM port
    typedef struct packed {
        logic [10:0] addr;
        logic        we;
        logic [15:0] wdata;
    } tbl_acc_t;

    typedef struct packed {
        logic [1:0] prio;
        logic [5:0] pal;
        logic [3:0] color;      // 0 is transparent
    } pix_t;

    typedef enum logic [2:0] {
        S_IDLE, S_CHECK, S_XPOS, S_PITCH, S_OFFSET, S_ATTR, S_WBACK, S_ISSUE
    } scan_st_t;

    typedef enum logic [1:0] {
        D_IDLE, D_FETCH0, D_FETCH1, D_WRITE
    } draw_st_t;

endpackage
